// ==== common/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data path and pc width
`define EXEC_XLEN       32

// physical register file size and tag width
`define EXEC_PHYS_REGS  64
`define EXEC_TAG_W      6

// operation code width as encoded by the issue queue
`define EXEC_OPTYPE_W   4

`endif

// ==== common/exec_pkg.sv ====
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

    // data or pc word
    typedef logic [`EXEC_XLEN-1:0] word_t;

    // physical register tag
    typedef logic [`EXEC_TAG_W-1:0] phys_tag_t;

    // alu operation codes, 10 to 15 are undefined and yield zero
    typedef enum logic [`EXEC_OPTYPE_W-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9
    } optype_e;

endpackage

`default_nettype wire

// ==== common/issue_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

// one issued operation with its operand values
interface issue_if;
    logic                       valid;
    logic [`EXEC_XLEN-1:0]      pc;
    logic [`EXEC_OPTYPE_W-1:0]  optype;
    logic [`EXEC_XLEN-1:0]      src1_val;
    logic [`EXEC_XLEN-1:0]      src2_val;
    logic [`EXEC_XLEN-1:0]      imm;
    logic                       use_imm;
    logic [`EXEC_TAG_W-1:0]     dest;

    modport producer (
        output valid, pc, optype, src1_val, src2_val, imm, use_imm, dest
    );

    modport lane (
        input  valid, pc, optype, src1_val, src2_val, imm, use_imm, dest
    );
endinterface

`default_nettype wire

// ==== common/result_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

// one lane result heading for writeback
interface result_if;
    logic                       valid;
    logic [`EXEC_XLEN-1:0]      pc;
    logic [`EXEC_TAG_W-1:0]     dest;
    logic [`EXEC_XLEN-1:0]      data;

    modport lane (
        output valid, pc, dest, data
    );

    modport complete (
        input  valid, pc, dest, data
    );
endinterface

`default_nettype wire

// ==== verilog/alu_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module alu_lane (
    input  wire     clk,
    input  wire     rst_n,
    issue_if.lane   issue,
    result_if.lane  result
);
    import exec_pkg::*;

    optype_e    op;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    logic [4:0] shamt;

    assign op   = optype_e'(issue.optype);
    assign op_a = issue.src1_val;

    // second operand is the immediate for i-type ops
    assign op_b  = issue.use_imm ? issue.imm : issue.src2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (op)
            op_add:  alu_out = op_a + op_b;
            op_sub:  alu_out = op_a - op_b;
            op_and:  alu_out = op_a & op_b;
            op_or:   alu_out = op_a | op_b;
            op_xor:  alu_out = op_a ^ op_b;
            op_sll:  alu_out = op_a << shamt;
            op_srl:  alu_out = op_a >> shamt;
            op_sra:  alu_out = $signed(op_a) >>> shamt;
            op_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            op_sltu: alu_out = word_t'(op_a < op_b);
            // undefined codes
            default: alu_out = '0;
        endcase
    end

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
    end

    // payload only moves on an issue
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result.data <= alu_out;
            result.dest <= issue.dest;
            result.pc   <= issue.pc;
        end
    end

    // the issue queue must never hand over a half-driven opcode
    optype_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.valid |-> !$isunknown(issue.optype)
    );

endmodule

`default_nettype wire

// ==== complete/prf_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module prf_bank (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     we0,
    input  wire exec_pkg::phys_tag_t wtag0,
    input  wire exec_pkg::word_t    wdata0,
    input  wire                     we1,
    input  wire exec_pkg::phys_tag_t wtag1,
    input  wire exec_pkg::word_t    wdata1,
    input  wire                     clr_valid,
    input  wire exec_pkg::phys_tag_t clr_tag,
    input  wire exec_pkg::phys_tag_t rtag,
    output exec_pkg::word_t         rdata,
    output logic                    rready
);
    import exec_pkg::*;

    word_t                      regs [`EXEC_PHYS_REGS];
    logic [`EXEC_PHYS_REGS-1:0] ready;

    // later assignments win, so a write beats a clear and port 1 beats port 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '0;
        end else begin
            if (clr_valid) begin
                ready[clr_tag] <= 1'b0;
            end
            if (we0) begin
                regs[wtag0]  <= wdata0;
                ready[wtag0] <= 1'b1;
            end
            if (we1) begin
                regs[wtag1]  <= wdata1;
                ready[wtag1] <= 1'b1;
            end
        end
    end

    // combinational read
    assign rdata  = regs[rtag];
    assign rready = ready[rtag];

endmodule

`default_nettype wire

// ==== complete/complete_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module complete_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    result_if.complete              res0,
    result_if.complete              res1,
    input  wire                     alloc_valid,
    input  wire exec_pkg::phys_tag_t alloc_tag,
    input  wire exec_pkg::phys_tag_t rd_tag,
    output exec_pkg::word_t         rd_data,
    output logic                    rd_ready,
    output logic                    comp0_valid,
    output exec_pkg::word_t         comp0_pc,
    output logic                    comp1_valid,
    output exec_pkg::word_t         comp1_pc
);
    import exec_pkg::*;

    // writeback stage, one slot per lane
    logic   wb_valid [2];
    word_t  wb_pc    [2];

    // results land in the register file at the same edge as the
    // completion report, so the tag reads back as soon as comp is seen
    prf_bank prf (
        .clk        (clk),
        .rst_n      (rst_n),
        .we0        (res0.valid),
        .wtag0      (res0.dest),
        .wdata0     (res0.data),
        .we1        (res1.valid),
        .wtag1      (res1.dest),
        .wdata1     (res1.data),
        .clr_valid  (alloc_valid),
        .clr_tag    (alloc_tag),
        .rtag       (rd_tag),
        .rdata      (rd_data),
        .rready     (rd_ready)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid[0] <= 1'b0;
            wb_valid[1] <= 1'b0;
        end else begin
            wb_valid[0] <= res0.valid;
            wb_valid[1] <= res1.valid;
        end
    end

    // pcs are payload, held until the next valid result
    always_ff @(posedge clk) begin
        if (res0.valid) begin
            wb_pc[0] <= res0.pc;
        end
        if (res1.valid) begin
            wb_pc[1] <= res1.pc;
        end
    end

    // both lanes report even when they hit the same tag
    assign comp0_valid = wb_valid[0];
    assign comp0_pc    = wb_pc[0];
    assign comp1_valid = wb_valid[1];
    assign comp1_pc    = wb_pc[1];

    // a lane result with an unknown tag would corrupt a random register
    res0_dest_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        res0.valid |-> !$isunknown(res0.dest)
    );

    res1_dest_known_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        res1.valid |-> !$isunknown(res1.dest)
    );

endmodule

`default_nettype wire

// ==== verilog/exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module exec_core (
    input  wire                             clk,
    input  wire                             rst_n,
    // lane 0 issue slot
    input  wire                             issue0_valid,
    input  wire exec_pkg::word_t            issue0_pc,
    input  wire [`EXEC_OPTYPE_W-1:0]        issue0_optype,
    input  wire exec_pkg::word_t            issue0_src1,
    input  wire exec_pkg::word_t            issue0_src2,
    input  wire exec_pkg::word_t            issue0_imm,
    input  wire                             issue0_use_imm,
    input  wire exec_pkg::phys_tag_t        issue0_dest,
    // lane 1 issue slot
    input  wire                             issue1_valid,
    input  wire exec_pkg::word_t            issue1_pc,
    input  wire [`EXEC_OPTYPE_W-1:0]        issue1_optype,
    input  wire exec_pkg::word_t            issue1_src1,
    input  wire exec_pkg::word_t            issue1_src2,
    input  wire exec_pkg::word_t            issue1_imm,
    input  wire                             issue1_use_imm,
    input  wire exec_pkg::phys_tag_t        issue1_dest,
    // rename stand-in
    input  wire                             alloc_valid,
    input  wire exec_pkg::phys_tag_t        alloc_tag,
    // register file read port
    input  wire exec_pkg::phys_tag_t        rd_tag,
    output exec_pkg::word_t                 rd_data,
    output logic                            rd_ready,
    // completion reports
    output logic                            comp0_valid,
    output exec_pkg::word_t                 comp0_pc,
    output logic                            comp1_valid,
    output exec_pkg::word_t                 comp1_pc
);

    issue_if  iss0 ();
    issue_if  iss1 ();
    result_if res0 ();
    result_if res1 ();

    assign iss0.valid    = issue0_valid;
    assign iss0.pc       = issue0_pc;
    assign iss0.optype   = issue0_optype;
    assign iss0.src1_val = issue0_src1;
    assign iss0.src2_val = issue0_src2;
    assign iss0.imm      = issue0_imm;
    assign iss0.use_imm  = issue0_use_imm;
    assign iss0.dest     = issue0_dest;

    assign iss1.valid    = issue1_valid;
    assign iss1.pc       = issue1_pc;
    assign iss1.optype   = issue1_optype;
    assign iss1.src1_val = issue1_src1;
    assign iss1.src2_val = issue1_src2;
    assign iss1.imm      = issue1_imm;
    assign iss1.use_imm  = issue1_use_imm;
    assign iss1.dest     = issue1_dest;

    alu_lane lane0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (iss0.lane),
        .result (res0.lane)
    );

    alu_lane lane1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (iss1.lane),
        .result (res1.lane)
    );

    complete_stage complete (
        .clk            (clk),
        .rst_n          (rst_n),
        .res0           (res0.complete),
        .res1           (res1.complete),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .rd_tag         (rd_tag),
        .rd_data        (rd_data),
        .rd_ready       (rd_ready),
        .comp0_valid    (comp0_valid),
        .comp0_pc       (comp0_pc),
        .comp1_valid    (comp1_valid),
        .comp1_pc       (comp1_pc)
    );

endmodule

`default_nettype wire

// ==== sim/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// register file and ready bits as the testbench expects them
logic [`EXEC_XLEN-1:0]  m_regs  [`EXEC_PHYS_REGS];
logic                   m_ready [`EXEC_PHYS_REGS];

// two-deep pipeline per lane, p1 is the alu stage and p2 the writeback stage
logic                   p1_valid [2];
logic [`EXEC_XLEN-1:0]  p1_pc    [2];
logic [`EXEC_TAG_W-1:0] p1_dest  [2];
logic [`EXEC_XLEN-1:0]  p1_data  [2];
logic                   p2_valid [2];
logic [`EXEC_XLEN-1:0]  p2_pc    [2];

function automatic logic [`EXEC_XLEN-1:0] alu_ref(input logic [`EXEC_OPTYPE_W-1:0] op,
                                                  input logic [`EXEC_XLEN-1:0] a,
                                                  input logic [`EXEC_XLEN-1:0] b);
    logic [`EXEC_XLEN-1:0] r;
    case (op)
        4'd0: r = a + b;
        4'd1: r = a - b;
        4'd2: r = a & b;
        4'd3: r = a | b;
        4'd4: r = a ^ b;
        4'd5: r = a << b[4:0];
        4'd6: r = a >> b[4:0];
        4'd7: r = $unsigned($signed(a) >>> b[4:0]);
        4'd8: r = {31'd0, $signed(a) < $signed(b)};
        4'd9: r = {31'd0, a < b};
        default: r = '0;
    endcase
    return r;
endfunction

task automatic model_reset();
    for (int i = 0; i < `EXEC_PHYS_REGS; i++) begin
        m_regs[i] = '0;
        m_ready[i] = 1'b0;
    end
    for (int l = 0; l < 2; l++) begin
        p1_valid[l] = 1'b0;
        p2_valid[l] = 1'b0;
    end
endtask

`endif

// ==== sim/tb_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module tb_exec_core;
    // reset, post-reset reads, directed ops, undefined ops, random run, tag tests
    localparam int TEST_LEN = 3 + 64 + 20 * 3 + 6 * 3 + 2003 + 3 + 2 + 3 + 4;
    localparam int CYCLE_LIMIT = TEST_LEN + 20;

    logic                       clk;
    logic                       rst_n;
    logic                       iv    [2];
    logic [`EXEC_XLEN-1:0]      ipc   [2];
    logic [`EXEC_OPTYPE_W-1:0]  iop   [2];
    logic [`EXEC_XLEN-1:0]      ia    [2];
    logic [`EXEC_XLEN-1:0]      ib    [2];
    logic [`EXEC_XLEN-1:0]      iimm  [2];
    logic                       iuse  [2];
    logic [`EXEC_TAG_W-1:0]     idest [2];
    logic                       alloc_v;
    logic [`EXEC_TAG_W-1:0]     alloc_t;
    logic [`EXEC_TAG_W-1:0]     rd_tag;
    wire  [`EXEC_XLEN-1:0]      rd_data;
    wire                        rd_ready;
    wire                        comp0_valid;
    wire  [`EXEC_XLEN-1:0]      comp0_pc;
    wire                        comp1_valid;
    wire  [`EXEC_XLEN-1:0]      comp1_pc;
    int                         cycles;
    logic [`EXEC_TAG_W-1:0]     t0;
    logic [`EXEC_XLEN-1:0]      exp_data;

    `include "exec_model.svh"

    exec_core exec_core_i (
        .clk(clk), .rst_n(rst_n),
        .issue0_valid(iv[0]), .issue0_pc(ipc[0]), .issue0_optype(iop[0]),
        .issue0_src1(ia[0]), .issue0_src2(ib[0]), .issue0_imm(iimm[0]),
        .issue0_use_imm(iuse[0]), .issue0_dest(idest[0]),
        .issue1_valid(iv[1]), .issue1_pc(ipc[1]), .issue1_optype(iop[1]),
        .issue1_src1(ia[1]), .issue1_src2(ib[1]), .issue1_imm(iimm[1]),
        .issue1_use_imm(iuse[1]), .issue1_dest(idest[1]),
        .alloc_valid(alloc_v), .alloc_tag(alloc_t),
        .rd_tag(rd_tag), .rd_data(rd_data), .rd_ready(rd_ready),
        .comp0_valid(comp0_valid), .comp0_pc(comp0_pc),
        .comp1_valid(comp1_valid), .comp1_pc(comp1_pc)
    );

    always #20 clk = ~clk;

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("Fail at %0t ns: %s", $time, msg);
            $display("STATUS: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_lane(input int l, input logic [`EXEC_OPTYPE_W-1:0] op,
                              input logic u, input logic [`EXEC_TAG_W-1:0] d);
        iv[l]    <= 1'b1;
        ipc[l]   <= 32'($urandom()) & 32'hffff_fffc;
        iop[l]   <= op;
        ia[l]    <= 32'($urandom());
        ib[l]    <= 32'($urandom());
        iimm[l]  <= 32'($urandom());
        iuse[l]  <= u;
        idest[l] <= d;
    endtask

    task automatic go_idle();
        iv[0]   <= 1'b0;
        iv[1]   <= 1'b0;
        alloc_v <= 1'b0;
    endtask

    // issue on both lanes, then look at completion two cycles later
    task automatic run_directed(input logic [`EXEC_OPTYPE_W-1:0] op, input logic u,
                                input logic want_zero);
        logic [`EXEC_TAG_W-1:0] d;
        @(posedge clk);
        d = 6'($urandom());
        drive_lane(0, op, u, d);
        drive_lane(1, op, u, d ^ 6'd1);
        @(posedge clk);
        go_idle();
        rd_tag <= d;
        @(posedge clk);
        @(negedge clk);
        expect_true(comp0_valid && comp0_pc == ipc[0],
                    $sformatf("lane 0 completion for op %0d wrong", op));
        expect_true(comp1_valid && comp1_pc == ipc[1],
                    $sformatf("lane 1 completion for op %0d wrong", op));
        expect_true(rd_ready, $sformatf("tag %0d not ready after op %0d", d, op));
        if (want_zero) begin
            expect_true(rd_data == '0, $sformatf("undefined op %0d gave %h", op, rd_data));
        end
    endtask

    // model follows the DUT edge by edge, writes from p1 land at this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
        end else begin
            if (alloc_v) begin
                m_ready[alloc_t] = 1'b0;
            end
            for (int l = 0; l < 2; l++) begin
                if (p1_valid[l]) begin
                    m_regs[p1_dest[l]] = p1_data[l];
                    m_ready[p1_dest[l]] = 1'b1;
                end
            end
            for (int l = 0; l < 2; l++) begin
                p2_valid[l] = p1_valid[l];
                p2_pc[l] = p1_pc[l];
                p1_valid[l] = iv[l];
                if (iv[l]) begin
                    p1_pc[l] = ipc[l];
                    p1_dest[l] = idest[l];
                    p1_data[l] = alu_ref(iop[l], ia[l], iuse[l] ? iimm[l] : ib[l]);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            expect_true(comp0_valid == p2_valid[0], "comp0_valid differs from model");
            expect_true(comp1_valid == p2_valid[1], "comp1_valid differs from model");
            expect_true(!p2_valid[0] || comp0_pc == p2_pc[0],
                        $sformatf("comp0_pc %h, model %h", comp0_pc, p2_pc[0]));
            expect_true(!p2_valid[1] || comp1_pc == p2_pc[1],
                        $sformatf("comp1_pc %h, model %h", comp1_pc, p2_pc[1]));
            expect_true(rd_data == m_regs[rd_tag],
                        $sformatf("tag %0d data %h, model %h", rd_tag, rd_data,
                                  m_regs[rd_tag]));
            expect_true(rd_ready == m_ready[rd_tag],
                        $sformatf("tag %0d ready %0b, model %0b", rd_tag, rd_ready,
                                  m_ready[rd_tag]));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test did not finish", cycles);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk = 1'b0;
        cycles = 0;
        rst_n <= 1'b0;
        for (int l = 0; l < 2; l++) begin
            iv[l] <= 1'b0;
            ipc[l] <= '0;
            iop[l] <= '0;
            ia[l] <= '0;
            ib[l] <= '0;
            iimm[l] <= '0;
            iuse[l] <= 1'b0;
            idest[l] <= '0;
        end
        alloc_v <= 1'b0;
        alloc_t <= '0;
        rd_tag <= '0;
        void'($urandom(55377));

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // every tag empty after reset
        for (int t = 0; t < `EXEC_PHYS_REGS; t++) begin
            @(posedge clk);
            rd_tag <= 6'(t);
            @(negedge clk);
            expect_true(!comp0_valid && !comp1_valid, "completion high after reset");
            expect_true(!rd_ready && rd_data == '0,
                        $sformatf("tag %0d not clear after reset", t));
        end

        for (int op = 0; op < 10; op++) begin
            run_directed(4'(op), 1'b0, 1'b0);
            run_directed(4'(op), 1'b1, 1'b0);
        end
        for (int op = 10; op < 16; op++) begin
            run_directed(4'(op), 1'($urandom()), 1'b1);
        end

        // back-to-back random traffic, undefined codes included
        repeat (2000) begin
            @(posedge clk);
            drive_lane(0, 4'($urandom()), 1'($urandom()), 6'($urandom()));
            drive_lane(1, 4'($urandom()), 1'($urandom()), 6'($urandom()));
            alloc_v <= ($urandom() % 4) == 0;
            alloc_t <= 6'($urandom());
            rd_tag <= 6'($urandom());
        end
        @(posedge clk);
        go_idle();
        repeat (2) @(posedge clk);

        // both lanes on one tag, lane 1 wins
        @(posedge clk);
        t0 = 6'($urandom());
        drive_lane(0, 4'd0, 1'b0, t0);
        drive_lane(1, 4'd0, 1'b0, t0);
        @(posedge clk);
        go_idle();
        rd_tag <= t0;
        @(posedge clk);
        @(negedge clk);
        exp_data = ia[1] + ib[1];
        expect_true(rd_data == exp_data,
                    $sformatf("same tag write kept %h, lane 1 gave %h", rd_data, exp_data));

        // allocate alone clears ready
        @(posedge clk);
        alloc_v <= 1'b1;
        alloc_t <= t0;
        @(posedge clk);
        alloc_v <= 1'b0;
        @(negedge clk);
        expect_true(!rd_ready, "allocate did not clear the ready bit");

        // allocate at the same edge as the write keeps ready set
        @(posedge clk);
        drive_lane(0, 4'd3, 1'b1, t0);
        @(posedge clk);
        go_idle();
        alloc_v <= 1'b1;
        alloc_t <= t0;
        @(posedge clk);
        alloc_v <= 1'b0;
        @(negedge clk);
        expect_true(rd_ready, "write did not win over a coinciding allocate");

        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_core.f ====
+incdir+common
+incdir+sim
common/exec_pkg.sv
common/issue_if.sv
common/result_if.sv
verilog/alu_lane.sv
complete/prf_bank.sv
complete/complete_stage.sv
verilog/exec_core.sv
sim/tb_exec_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_exec_core
FILELIST  = exec_core.f
LOG       = sim.log

.PHONY: sim clean

# pass or fail is taken from the log, not from the exit code of tee
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
